// ==== hdl/arcade_pkg.sv ====
/*
 * game variant codes, control vector types and field indices,
 * PIA input byte type, orientation codes and service pulse length
 */
`default_nettype none

package arcade_pkg;

	typedef logic [6:0] game_code_t;	// variant code from the menu

	localparam game_code_t GAME_DEFENDER = 7'd0;
	localparam game_code_t GAME_COLONY7  = 7'd1;
	localparam game_code_t GAME_MAYDAY   = 7'd2;
	localparam game_code_t GAME_JIN      = 7'd3;

	typedef logic [7:0] pia_byte_t;

	// right, left, down, up, fireA..fireF from bit 0
	typedef logic [9:0] player_ctrl_t;
	localparam int CTRL_RIGHT  = 0;
	localparam int CTRL_LEFT   = 1;
	localparam int CTRL_DOWN   = 2;
	localparam int CTRL_UP     = 3;
	localparam int CTRL_FIRE_A = 4;
	localparam int CTRL_FIRE_B = 5;
	localparam int CTRL_FIRE_C = 6;
	localparam int CTRL_FIRE_D = 7;

	typedef logic [3:0] sys_ctrl_t;
	localparam int SYS_ONE_PLAYER  = 0;
	localparam int SYS_TWO_PLAYERS = 1;
	localparam int SYS_COIN1       = 2;
	localparam int SYS_COIN2       = 3;

	typedef logic [1:0] orient_t;	// [left/right, landscape/portrait]
	localparam orient_t ORIENT_DEFAULT = 2'b10;
	localparam orient_t ORIENT_COLONY7 = 2'b01;
	localparam orient_t ORIENT_JIN     = 2'b11;

	typedef logic [15:0] status_t;	// menu option bits
	localparam int ST_RESET    = 0;
	localparam int ST_AUTOUP   = 7;
	localparam int ST_ADVANCE  = 8;
	localparam int ST_HSRESET  = 9;
	localparam int ST_DIP_BASE = 10;	// three dip bits from here up

	localparam int unsigned PULSE_CYCLES_DEFAULT = 1048575;

endpackage

`default_nettype wire

// ==== hdl/defender_glue_top.sv ====
/* defender_glue_top: board glue around the Williams game core, plain ports */
`timescale 1ns/1ps
`default_nettype none

module defender_glue_top
	import arcade_pkg::*;
	import rom_pkg::*;
#(
	parameter int unsigned PULSE_CYCLES = PULSE_CYCLES_DEFAULT
) (
	input  logic         clk_sys,
	input  logic         rst_n,
	input  status_t      status_bits,
	input  logic         reset_button,
	input  game_code_t   core_mod,
	input  player_ctrl_t p1_ctrl,
	input  sys_ctrl_t    sys_ctrl,
	input  logic         ioctl_download,
	input  logic         ioctl_wr,
	input  dl_addr_t     ioctl_addr,
	input  pia_byte_t    ioctl_dout,
	input  cpu_addr_t    main_rom_addr,
	input  rom_word_t    main_word_q,
	input  logic         snd_vma,
	input  snd_addr_t    snd_rom_addr,
	input  rom_word_t    snd_word_q,
	// store write ports
	output logic         port1_req,
	output logic         port2_req,
	output store_addr_t  port1_a,
	output store_addr_t  port2_a,
	output logic [1:0]   port_ds,
	output logic         port_we,
	output rom_word_t    port_d,
	// core inputs
	output pia_byte_t    input0,
	output pia_byte_t    input1,
	output pia_byte_t    input2,
	output logic         mayday,
	output orient_t      orientation,
	output logic         core_reset,
	output logic         rom_loaded,
	// rom fetch
	output fetch_addr_t  main_word_addr,
	output fetch_addr_t  snd_word_addr,
	output pia_byte_t    main_rom_byte,
	output pia_byte_t    snd_rom_byte,
	output logic         led
);

	logic advance;
	logic hsreset;

	pulse_stretch #(.PULSE_CYCLES(PULSE_CYCLES)) adv_stretch (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.btn     (status_bits[ST_ADVANCE]),
		.pulse   (advance)
	);

	pulse_stretch #(.PULSE_CYCLES(PULSE_CYCLES)) hsr_stretch (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.btn     (status_bits[ST_HSRESET]),
		.pulse   (hsreset)
	);

	input_mapper i_input_mapper (
		.core_mod    (core_mod),
		.p1          (p1_ctrl),
		.sys         (sys_ctrl),
		.status      (status_bits),
		.advance     (advance),
		.hsreset     (hsreset),
		.input0      (input0),
		.input1      (input1),
		.input2      (input2),
		.mayday      (mayday),
		.orientation (orientation)
	);

	rom_loader i_rom_loader (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.port1_req      (port1_req),
		.port2_req      (port2_req),
		.port1_a        (port1_a),
		.port2_a        (port2_a),
		.port_ds        (port_ds),
		.port_we        (port_we),
		.port_d         (port_d)
	);

	reset_sequencer i_reset_sequencer (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.menu_reset     (status_bits[ST_RESET]),
		.reset_button   (reset_button),
		.core_reset     (core_reset),
		.rom_loaded     (rom_loaded)
	);

	rom_byte_select i_rom_byte_select (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.main_rom_addr  (main_rom_addr),
		.main_word_q    (main_word_q),
		.snd_vma        (snd_vma),
		.snd_rom_addr   (snd_rom_addr),
		.snd_word_q     (snd_word_q),
		.main_word_addr (main_word_addr),
		.snd_word_addr  (snd_word_addr),
		.main_rom_byte  (main_rom_byte),
		.snd_rom_byte   (snd_rom_byte)
	);

	assign led = ~ioctl_download;	// dark while downloading

endmodule

`default_nettype wire

// ==== hdl/input_mapper.sv ====
/* input_mapper: per game packing of the PIA input bytes, protection and orientation */
`timescale 1ns/1ps
`default_nettype none

module input_mapper
	import arcade_pkg::*;
(
	input  game_code_t   core_mod,
	input  player_ctrl_t p1,
	input  sys_ctrl_t    sys,
	input  status_t      status,
	input  logic         advance,
	input  logic         hsreset,
	output pia_byte_t    input0,
	output pia_byte_t    input1,
	output pia_byte_t    input2,
	output logic         mayday,
	output orient_t      orientation
);

	logic       right, left, down, up;
	logic       fire_a, fire_b, fire_c, fire_d;
	logic       one_player, two_players, coin1, coin2;
	logic       auto_up;
	logic [2:0] dip;

	assign right       = p1[CTRL_RIGHT];
	assign left        = p1[CTRL_LEFT];
	assign down        = p1[CTRL_DOWN];
	assign up          = p1[CTRL_UP];
	assign fire_a      = p1[CTRL_FIRE_A];
	assign fire_b      = p1[CTRL_FIRE_B];
	assign fire_c      = p1[CTRL_FIRE_C];
	assign fire_d      = p1[CTRL_FIRE_D];
	assign one_player  = sys[SYS_ONE_PLAYER];
	assign two_players = sys[SYS_TWO_PLAYERS];
	assign coin1       = sys[SYS_COIN1];
	assign coin2       = sys[SYS_COIN2];
	assign auto_up     = status[ST_AUTOUP];
	assign dip         = status[ST_DIP_BASE +: 3];

	always_comb begin
		input0      = '0;
		input1      = '0;
		input2      = '0;
		mayday      = 1'b0;
		orientation = ORIENT_DEFAULT;

		case (core_mod)
			GAME_DEFENDER: begin
				input0 = {3'b000, coin1, hsreset, 1'b0, advance, auto_up};
				// reverse on either horizontal direction
				input1 = {down, left | right, one_player, two_players,
					fire_d, fire_c, fire_b, fire_a};
				input2 = {7'b0000000, up};
			end
			GAME_COLONY7: begin
				orientation = ORIENT_COLONY7;
				input0 = {3'b000, coin1, 2'b00, dip[1], dip[0]};	// bonus, lives
				input1 = {fire_b, fire_a, one_player, two_players, up, left, right, down};
				input2 = {7'b0000000, fire_c};
			end
			GAME_MAYDAY: begin
				mayday = 1'b1;	// protection on
				input0 = {2'b00, coin2, coin1, 1'b0, hsreset, advance, auto_up};
				input1 = {down, 1'b0, one_player, two_players, fire_b, fire_c, right, fire_a};
				input2 = {7'b0000000, up};
			end
			GAME_JIN: begin
				orientation = ORIENT_JIN;
				input0 = {3'b000, coin2, coin1, 3'b000};
				input1 = {fire_b, fire_a, one_player, two_players, right, left, down, up};
				input2 = {1'b0, ~dip[2], ~dip[1], 1'b0, dip[0], 3'b000};	// level, lives
			end
			default: ;	// unused code, all bytes zero
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/pulse_stretch.sv ====
/* pulse_stretch: fixed length pulse from a button rising edge */
`timescale 1ns/1ps
`default_nettype none

module pulse_stretch
	import arcade_pkg::*;
#(
	parameter int unsigned PULSE_CYCLES = PULSE_CYCLES_DEFAULT
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic btn,
	output logic pulse
);

	localparam int CNT_W = $clog2(PULSE_CYCLES + 1);

	logic             btn_d;	// previous sample
	logic [CNT_W-1:0] count;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			btn_d <= 1'b0;
			count <= '0;
		end else begin
			btn_d <= btn;
			if (btn && !btn_d)
				count <= CNT_W'(PULSE_CYCLES);	// restart, also mid pulse
			else if (count != '0)
				count <= count - 1'b1;
		end
	end

	assign pulse = (count != '0);

endmodule

`default_nettype wire

// ==== hdl/reset_sequencer.sv ====
/* reset_sequencer: ROM load tracking and registered core reset */
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic ioctl_download,
	input  logic menu_reset,
	input  logic reset_button,
	output logic core_reset,
	output logic rom_loaded
);

	logic download_d;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			download_d <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			download_d <= ioctl_download;
			if (download_d && !ioctl_download)
				rom_loaded <= 1'b1;	// sticky until rst_n
			// sees the old rom_loaded, so release comes one edge after it
			core_reset <= menu_reset | reset_button | ioctl_download | ~rom_loaded;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/rom_byte_select.sv ====
/* rom_byte_select: fetch word addresses, sound address latch, byte picking */
`timescale 1ns/1ps
`default_nettype none

module rom_byte_select
	import arcade_pkg::*;
	import rom_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        ioctl_download,
	input  cpu_addr_t   main_rom_addr,
	input  rom_word_t   main_word_q,
	input  logic        snd_vma,
	input  snd_addr_t   snd_rom_addr,
	input  rom_word_t   snd_word_q,
	output fetch_addr_t main_word_addr,
	output fetch_addr_t snd_word_addr,
	output pia_byte_t   main_rom_byte,
	output pia_byte_t   snd_rom_byte
);

	logic      vma_r, vma_r2;
	snd_addr_t snd_addr_q;	// latched sound cpu address

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vma_r      <= 1'b0;
			vma_r2     <= 1'b0;
			snd_addr_q <= '0;
		end else begin
			vma_r  <= snd_vma;
			vma_r2 <= vma_r;
			if (vma_r2)
				snd_addr_q <= snd_rom_addr;
		end
	end

	assign main_word_addr = ioctl_download ? FETCH_IDLE_ADDR : fetch_addr_t'(main_rom_addr[14:1]);
	assign snd_word_addr  = ioctl_download ? FETCH_IDLE_ADDR : fetch_addr_t'(snd_addr_q[10:1]);

	// odd address takes the high byte
	assign main_rom_byte = main_rom_addr[0] ? main_word_q[15:8] : main_word_q[7:0];
	assign snd_rom_byte  = snd_addr_q[0] ? snd_word_q[15:8] : snd_word_q[7:0];

endmodule

`default_nettype wire

// ==== hdl/rom_loader.sv ====
/* rom_loader: download strobes to two toggle request store write ports */
`timescale 1ns/1ps
`default_nettype none

module rom_loader
	import arcade_pkg::*;
	import rom_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        ioctl_download,
	input  logic        ioctl_wr,
	input  dl_addr_t    ioctl_addr,
	input  pia_byte_t   ioctl_dout,
	output logic        port1_req,
	output logic        port2_req,
	output store_addr_t port1_a,
	output store_addr_t port2_a,
	output logic [1:0]  port_ds,
	output logic        port_we,
	output rom_word_t   port_d
);

	logic wr_last;
	logic wr_rise;

	assign wr_rise = ioctl_wr && !wr_last;

	// each level change is one request to the store
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_last   <= 1'b0;
			port1_req <= 1'b0;
			port2_req <= 1'b0;
		end else begin
			wr_last <= ioctl_wr;
			if (ioctl_download && wr_rise) begin
				port1_req <= ~port1_req;
				port2_req <= ~port2_req;
			end
		end
	end

	// word address, port 2 sees the sound region at word 0
	assign port1_a = ioctl_addr[23:1];
	assign port2_a = ioctl_addr[23:1] - SND_WORD_BASE;

	assign port_ds = {ioctl_addr[0], ~ioctl_addr[0]};	// odd byte goes high
	assign port_d  = {ioctl_dout, ioctl_dout};
	assign port_we = ioctl_download;

endmodule

`default_nettype wire

// ==== hdl/rom_pkg.sv ====
/*
 * ROM download map, store and fetch address types, word type
 * and sound region offset
 */
`default_nettype none

package rom_pkg;

	typedef logic [24:0] dl_addr_t;	// download byte address
	typedef logic [22:0] store_addr_t;	// store word address
	typedef logic [15:0] rom_word_t;
	typedef logic [14:0] cpu_addr_t;	// main cpu byte address
	typedef logic [11:0] snd_addr_t;	// sound cpu byte address
	typedef logic [14:0] fetch_addr_t;	// fetch word address

	/*
	 * download image layout, byte addresses
	 * 0000-6FFF main cpu, 7000-73FF decoder, 7400-7BFF sound cpu
	 */
	localparam dl_addr_t SND_BYTE_BASE = 25'h7400;
	localparam store_addr_t SND_WORD_BASE = store_addr_t'(SND_BYTE_BASE >> 1);	// 3A00

	// parked fetch address while the store is being written
	localparam fetch_addr_t FETCH_IDLE_ADDR = '1;

endpackage

`default_nettype wire

// ==== list.f ====
hdl/arcade_pkg.sv
hdl/rom_pkg.sv
hdl/pulse_stretch.sv
hdl/input_mapper.sv
hdl/rom_loader.sv
hdl/reset_sequencer.sv
hdl/rom_byte_select.sv
hdl/defender_glue_top.sv
tests/defender_glue_checker.sv
tests/tb_defender_glue.sv

// ==== tests/defender_glue_checker.sv ====
/*
 * concurrent assertions on the core reset and the store write requests,
 * bound into reset_sequencer and rom_loader
 */
`timescale 1ns/1ps
`default_nettype none

module defender_glue_checker (
	input logic clk_sys,
	input logic rst_n,
	input logic ioctl_download,
	input logic core_reset,
	input logic rom_loaded,
	input logic port1_req,
	input logic port2_req
);

	int n_fail = 0;	// failed assertions, summed by the testbench

	// core stays in reset for the cycle after any download cycle
	a_reset_follows_download: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_download |=> core_reset)
		else begin
			n_fail++;
			$error("core_reset low in the cycle after a download cycle");
		end

	a_loaded_sticky: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!$fell(rom_loaded))
		else begin
			n_fail++;
			$error("rom_loaded fell while out of reset");
		end

	// a toggle must come from a strobe seen during the download
	a_req_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(port1_req != $past(port1_req) || port2_req != $past(port2_req))
			|-> $past(ioctl_download))
		else begin
			n_fail++;
			$error("store request changed outside a download");
		end

endmodule

// unused inputs tied to values that always hold
bind reset_sequencer defender_glue_checker i_seq_checker (
	.clk_sys (clk_sys), .rst_n (rst_n), .ioctl_download (ioctl_download),
	.core_reset (core_reset), .rom_loaded (rom_loaded),
	.port1_req (1'b0), .port2_req (1'b0)
);

bind rom_loader defender_glue_checker i_loader_checker (
	.clk_sys (clk_sys), .rst_n (rst_n), .ioctl_download (ioctl_download),
	.core_reset (1'b1), .rom_loaded (1'b0),
	.port1_req (port1_req), .port2_req (port2_req)
);

`default_nettype wire

// ==== tests/tb_defender_glue.sv ====
/*
 * testbench for the arcade board glue: clock, LFSR stimulus, reference
 * functions, per cycle compare process, watchdog and verdict
 */
`timescale 1ns/1ps
`default_nettype none

module tb_defender_glue
	import arcade_pkg::*;
	import rom_pkg::*;
();

	localparam int CLK_PERIOD = 4;
	localparam int PULSE_LEN = 8;
	localparam int N_BYTES = 40;
	localparam int N_MAP = 40;
	localparam int N_SND = 24;
	// worst case length of every test, in cycles
	localparam int TEST_CYCLES = 7 + 4 + N_BYTES * 6 + 6 + 5 * N_MAP + 2 * (PULSE_LEN + 2)
		+ N_SND * 7 + 4;
	localparam int WATCHDOG_CYCLES = TEST_CYCLES + 200;

	logic clk_sys;
	logic rst_n;
	status_t status_bits;
	logic reset_button;
	game_code_t core_mod;
	player_ctrl_t p1_ctrl;
	sys_ctrl_t sys_ctrl;
	logic ioctl_download;
	logic ioctl_wr;
	dl_addr_t ioctl_addr;
	pia_byte_t ioctl_dout;
	cpu_addr_t main_rom_addr;
	rom_word_t main_word_q;
	logic snd_vma;
	snd_addr_t snd_rom_addr;
	rom_word_t snd_word_q;
	logic port1_req, port2_req, port_we, mayday, core_reset, rom_loaded, led;
	store_addr_t port1_a, port2_a;
	logic [1:0] port_ds;
	rom_word_t port_d;
	pia_byte_t input0, input1, input2, main_rom_byte, snd_rom_byte;
	orient_t orientation;
	fetch_addr_t main_word_addr, snd_word_addr;

	// expected state kept by the stimulus
	logic checks_on;
	logic exp_req, exp_loaded, exp_core_reset, exp_adv, exp_hsr;
	snd_addr_t exp_snd;
	logic [15:0] lfsr_state;
	int n_checks;
	int n_errors;

	defender_glue_top #(.PULSE_CYCLES(PULSE_LEN)) i_defender_glue_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);	// galois, taps 16,14,13,11
	endfunction

	function logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		random_bits = r;
	endfunction

	// {input0, input1, input2, mayday, orientation} from the wiring tables
	function automatic logic [26:0] exp_mapper(input game_code_t code, input player_ctrl_t p,
		input sys_ctrl_t s, input status_t st, input logic adv, input logic hsr);
		pia_byte_t i0, i1, i2;
		logic prot;
		orient_t orient;
		i0 = '0;
		i1 = '0;
		i2 = '0;
		prot = 1'b0;
		orient = 2'b10;
		case (code)
			7'd0: begin	// defender
				i0 = {3'b0, s[2], hsr, 1'b0, adv, st[7]};
				i1 = {p[2], p[1] | p[0], s[0], s[1], p[7], p[6], p[5], p[4]};
				i2 = {7'b0, p[3]};
			end
			7'd1: begin	// colony 7
				orient = 2'b01;
				i0 = {3'b0, s[2], 2'b0, st[11], st[10]};
				i1 = {p[5], p[4], s[0], s[1], p[3], p[1], p[0], p[2]};
				i2 = {7'b0, p[6]};
			end
			7'd2: begin	// mayday
				prot = 1'b1;
				i0 = {2'b0, s[3], s[2], 1'b0, hsr, adv, st[7]};
				i1 = {p[2], 1'b0, s[0], s[1], p[5], p[6], p[0], p[4]};
				i2 = {7'b0, p[3]};
			end
			7'd3: begin	// jin
				orient = 2'b11;
				i0 = {3'b0, s[3], s[2], 3'b0};
				i1 = {p[5], p[4], s[0], s[1], p[0], p[1], p[2], p[3]};
				i2 = {1'b0, ~st[12], ~st[11], 1'b0, st[10], 3'b0};
			end
			default: ;
		endcase
		exp_mapper = {i0, i1, i2, prot, orient};
	endfunction

	// {port1_a, port2_a, port_ds, port_we, port_d}
	function automatic logic [64:0] exp_loader(input logic dl, input dl_addr_t a,
		input pia_byte_t d);
		store_addr_t w1;
		store_addr_t w2;
		logic [1:0] ds;
		w1 = a[23:1];
		w2 = w1 - 23'h3A00;	// sound rom lands at word 0 of port 2
		ds = a[0] ? 2'b10 : 2'b01;
		exp_loader = {w1, w2, ds, dl, d, d};
	endfunction

	function automatic logic [14:0] fetch_word(input logic dl, input logic [14:0] byte_addr);
		fetch_word = dl ? 15'h7FFF : {1'b0, byte_addr[14:1]};
	endfunction

	function automatic pia_byte_t pick_byte(input rom_word_t w, input logic odd);
		pick_byte = odd ? w[15:8] : w[7:0];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		n_checks++;
		assert (got === exp) else begin
			n_errors++;
			$display("ERROR at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic drive_random_fetch();
		main_rom_addr <= cpu_addr_t'(random_bits(15));
		main_word_q <= rom_word_t'(random_bits(16));
		snd_rom_addr <= snd_addr_t'(random_bits(12));
		snd_word_q <= rom_word_t'(random_bits(16));
	endtask

	// outputs settle after the rising edge, so compare on the falling one
	always @(negedge clk_sys) begin : compare
		logic [26:0] m;
		logic [64:0] l;
		if (checks_on) begin
			m = exp_mapper(core_mod, p1_ctrl, sys_ctrl, status_bits, exp_adv, exp_hsr);
			l = exp_loader(ioctl_download, ioctl_addr, ioctl_dout);
			check_value("input0", input0, m[26:19]);
			check_value("input1", input1, m[18:11]);
			check_value("input2", input2, m[10:3]);
			check_value("mayday", mayday, m[2]);
			check_value("orientation", orientation, m[1:0]);
			check_value("led", led, !ioctl_download);
			check_value("port1_req", port1_req, exp_req);
			check_value("port2_req", port2_req, exp_req);
			check_value("port1_a", port1_a, l[64:42]);
			check_value("port2_a", port2_a, l[41:19]);
			check_value("port_ds", port_ds, l[18:17]);
			check_value("port_we", port_we, l[16]);
			check_value("port_d", port_d, l[15:0]);
			check_value("core_reset", core_reset, exp_core_reset);
			check_value("rom_loaded", rom_loaded, exp_loaded);
			check_value("main_word_addr", main_word_addr,
				fetch_word(ioctl_download, main_rom_addr));
			check_value("snd_word_addr", snd_word_addr,
				fetch_word(ioctl_download, {4'b0, exp_snd[10:0]}));
			check_value("main_rom_byte", main_rom_byte, pick_byte(main_word_q, main_rom_addr[0]));
			check_value("snd_rom_byte", snd_rom_byte, pick_byte(snd_word_q, exp_snd[0]));
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the tests completed");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin : stimulus
		int gap;
		snd_addr_t t;
		game_code_t code;
		int n_fails;
		rst_n = 1'b0;
		status_bits = '0;
		reset_button = 1'b0;
		core_mod = '0;
		p1_ctrl = '0;
		sys_ctrl = '0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		main_rom_addr = '0;
		main_word_q = '0;
		snd_vma = 1'b0;
		snd_rom_addr = '0;
		snd_word_q = '0;
		checks_on = 1'b0;
		exp_req = 1'b0;
		exp_loaded = 1'b0;
		exp_core_reset = 1'b1;
		exp_adv = 1'b0;
		exp_hsr = 1'b0;
		exp_snd = '0;
		lfsr_state = 16'd4;
		n_checks = 0;
		n_errors = 0;

		repeat (5) @(posedge clk_sys);
		rst_n <= 1'b1;
		checks_on = 1'b1;	// first compare sees the reset values
		repeat (2) @(posedge clk_sys);

		// download with random bytes and strobe spacing
		ioctl_download <= 1'b1;
		for (int i = 0; i < N_BYTES; i++) begin
			@(posedge clk_sys);
			ioctl_wr <= 1'b1;
			ioctl_addr <= dl_addr_t'(random_bits(25));
			ioctl_dout <= pia_byte_t'(random_bits(8));
			@(posedge clk_sys);
			ioctl_wr <= 1'b0;
			exp_req = ~exp_req;	// toggle one edge after the strobe
			gap = 3 + int'(random_bits(2));
			repeat (gap - 2) @(posedge clk_sys);
		end
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		@(posedge clk_sys);
		exp_loaded = 1'b1;
		@(posedge clk_sys);
		exp_core_reset = 1'b0;

		// reset button, then menu reset
		for (int i = 0; i < 2; i++) begin
			@(posedge clk_sys);
			if (i == 0)
				reset_button <= 1'b1;
			else
				status_bits <= 16'h0001;
			@(posedge clk_sys);
			reset_button <= 1'b0;
			status_bits <= '0;
			exp_core_reset = 1'b1;
			@(posedge clk_sys);
			exp_core_reset = 1'b0;
		end

		// four games and one unused code, service buttons kept low
		for (int c = 0; c < 5; c++) begin
			code = (c == 4) ? 7'd77 : game_code_t'(c);
			for (int k = 0; k < N_MAP; k++) begin
				@(posedge clk_sys);
				core_mod <= code;
				p1_ctrl <= player_ctrl_t'(random_bits(10));
				sys_ctrl <= sys_ctrl_t'(random_bits(4));
				status_bits <= status_t'(random_bits(16)) & 16'hFCFE;
			end
		end
		@(posedge clk_sys);
		core_mod <= GAME_DEFENDER;
		status_bits <= '0;

		// advance then high score reset
		for (int b = 0; b < 2; b++) begin
			@(posedge clk_sys);
			status_bits <= (b == 0) ? 16'h0100 : 16'h0200;
			@(posedge clk_sys);
			if (b == 0)
				exp_adv = 1'b1;
			else
				exp_hsr = 1'b1;
			repeat (PULSE_LEN) @(posedge clk_sys);
			exp_adv = 1'b0;
			exp_hsr = 1'b0;
			status_bits <= '0;
		end

		// main bytes every cycle, sound address latched after each vma pulse
		for (int k = 0; k < N_SND; k++) begin
			@(posedge clk_sys);
			drive_random_fetch();
			snd_vma <= 1'b1;
			@(posedge clk_sys);
			drive_random_fetch();
			snd_vma <= 1'b0;
			@(posedge clk_sys);
			t = snd_addr_t'(random_bits(12));
			drive_random_fetch();
			snd_rom_addr <= t;
			@(posedge clk_sys);
			drive_random_fetch();
			exp_snd = t;
			repeat (int'(random_bits(2))) begin
				@(posedge clk_sys);
				drive_random_fetch();
			end
		end
		repeat (2) @(posedge clk_sys);

		n_fails = i_defender_glue_top.i_reset_sequencer.i_seq_checker.n_fail
			+ i_defender_glue_top.i_rom_loader.i_loader_checker.n_fail;
		$display("checks run: %0d, errors: %0d, assertion failures: %0d",
			n_checks, n_errors, n_fails);
		if (n_errors == 0 && n_fails == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
